// File: rtl/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// PC bits that index the BTB and the counter table
`define BP_INDEX_WIDTH 6

// Upper PC bits kept as the BTB tag
`define BP_TAG_WIDTH (32 - `BP_INDEX_WIDTH - 2)

// Fetch address after reset
`define BP_RESET_PC 32'h0000_0000

// Sequential fetch step in bytes
`define BP_INSTR_BYTES 32'd4

`endif

// File: rtl/bp_pkg.sv
`include "bp_consts.svh"

package bp_pkg;

    typedef logic [`BP_INDEX_WIDTH-1:0] bp_index_t;
    typedef logic [`BP_TAG_WIDTH-1:0]   bp_tag_t;

    // Two-bit saturating counter, upper bit is the guess
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } counter_e;

    // Next fetch address source
    typedef enum logic [1:0] {
        PC_SEQ        = 2'b00,
        PC_PRED       = 2'b01,
        PC_REDIR_FALL = 2'b10,
        PC_REDIR_TGT  = 2'b11
    } pc_sel_e;

    // What fetch presents each cycle
    typedef struct packed {
        logic [31:0] pc;
        logic        pred_taken;
        logic [31:0] pred_target;
    } fetch_pred_t;

    // Branch or jump outcome from execute, with the prediction fetch made
    typedef struct packed {
        logic        valid;
        logic        taken;
        logic [31:0] pc;
        logic [31:0] target;
        logic        pred_taken;
        logic [31:0] pred_target;
    } resolve_t;

    // One write toward both prediction tables
    typedef struct packed {
        logic        en;
        bp_index_t   index;
        bp_tag_t     tag;
        logic        taken;
        logic [31:0] target;
    } table_update_t;

endpackage

// File: rtl/btb.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module btb (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [31:0]           lookup_pc_i,
    input  bp_pkg::table_update_t update_i,
    output logic                  hit_o,
    output logic [31:0]           target_o
);

    localparam int DEPTH = 1 << `BP_INDEX_WIDTH;

    logic        valid_q  [DEPTH];
    logic [`BP_TAG_WIDTH-1:0] tag_q [DEPTH];
    logic [31:0] target_q [DEPTH];

    bp_pkg::bp_index_t lookup_index;
    bp_pkg::bp_tag_t   lookup_tag;
    logic              write_en;

    // Index sits just above the byte offset, tag takes the rest
    assign lookup_index = lookup_pc_i[`BP_INDEX_WIDTH+1:2];
    assign lookup_tag   = lookup_pc_i[31:`BP_INDEX_WIDTH+2];

    // Only taken branches allocate an entry
    assign write_en = update_i.en && update_i.taken;

    assign hit_o = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);

    // Zero target on a miss so fetch never shows stale data
    assign target_o = hit_o ? target_q[lookup_index] : 32'h0000_0000;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid_q[update_i.index] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            tag_q[update_i.index]    <= update_i.tag;
            target_q[update_i.index] <= update_i.target;
        end
    end

endmodule

// File: rtl/pattern_table.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module pattern_table (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  bp_pkg::bp_index_t     lookup_index_i,
    input  bp_pkg::table_update_t update_i,
    output logic                  guess_o
);

    localparam int DEPTH = 1 << `BP_INDEX_WIDTH;

    // Packed so the whole table can be checked at once
    bp_pkg::counter_e [DEPTH-1:0] counter_q;

    // One step toward the outcome, held at both ends
    function automatic bp_pkg::counter_e step_counter(input bp_pkg::counter_e cur,
                                                      input logic taken);
        bp_pkg::counter_e nxt;
        case (cur)
            bp_pkg::CNT_STRONG_NT: nxt = taken ? bp_pkg::CNT_WEAK_NT  : bp_pkg::CNT_STRONG_NT;
            bp_pkg::CNT_WEAK_NT:   nxt = taken ? bp_pkg::CNT_WEAK_T   : bp_pkg::CNT_STRONG_NT;
            bp_pkg::CNT_WEAK_T:    nxt = taken ? bp_pkg::CNT_STRONG_T : bp_pkg::CNT_WEAK_NT;
            default:               nxt = taken ? bp_pkg::CNT_STRONG_T : bp_pkg::CNT_WEAK_T;
        endcase
        return nxt;
    endfunction

    assign guess_o = counter_q[lookup_index_i][1];

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                counter_q[i] <= bp_pkg::CNT_WEAK_NT;
            end
        end else if (update_i.en) begin
            counter_q[update_i.index] <= step_counter(counter_q[update_i.index],
                                                      update_i.taken);
        end
    end

    // An unknown index or outcome from the resolve path would spread X here
    counter_known_a: assert property (
        @(posedge clk_i) disable iff (rst_i) !$isunknown(counter_q)
    ) else $error("pattern_table holds an unknown counter");

endmodule

// File: rtl/mispredict_unit.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module mispredict_unit (
    input  bp_pkg::resolve_t      resolve_i,
    output bp_pkg::table_update_t update_o,
    output bp_pkg::pc_sel_e       pc_sel_o,
    output logic [31:0]           redirect_pc_o,
    output logic                  flush_o
);

    logic dir_wrong;
    logic target_wrong;

    // Direction miss, or taken as guessed but to another address
    assign dir_wrong    = resolve_i.taken != resolve_i.pred_taken;
    assign target_wrong = resolve_i.taken && resolve_i.pred_taken &&
                          (resolve_i.target != resolve_i.pred_target);

    assign flush_o = resolve_i.valid && (dir_wrong || target_wrong);

    // Fall-through uses the branch PC, fetch_pc adds the step
    assign redirect_pc_o = resolve_i.taken ? resolve_i.target : resolve_i.pc;

    always_comb begin
        if (!flush_o) begin
            pc_sel_o = bp_pkg::PC_SEQ;
        end else if (resolve_i.taken) begin
            pc_sel_o = bp_pkg::PC_REDIR_TGT;
        end else begin
            pc_sel_o = bp_pkg::PC_REDIR_FALL;
        end
    end

    // Every resolve trains the counter, the BTB filters on taken itself
    assign update_o.en     = resolve_i.valid;
    assign update_o.index  = resolve_i.pc[`BP_INDEX_WIDTH+1:2];
    assign update_o.tag    = resolve_i.pc[31:`BP_INDEX_WIDTH+2];
    assign update_o.taken  = resolve_i.taken;
    assign update_o.target = resolve_i.target;

    // A redirect must come from a real resolve and land on a word boundary
    always_comb begin
        if (flush_o) begin
            flush_valid_a: assert (resolve_i.valid && (redirect_pc_o[1:0] == 2'b00))
                else $error("flush without a valid resolve or to an unaligned PC %h",
                            redirect_pc_o);
        end
    end

endmodule

// File: rtl/fetch_pc.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module fetch_pc (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            stall_i,
    input  logic            pred_taken_i,
    input  logic [31:0]     pred_target_i,
    input  bp_pkg::pc_sel_e pc_sel_i,
    input  logic [31:0]     redirect_pc_i,
    output logic [31:0]     pc_o
);

    logic [31:0]     pc_q;
    logic [31:0]     pc_next;
    bp_pkg::pc_sel_e sel;

    // Without a redirect the predictor decides
    always_comb begin
        if (pc_sel_i == bp_pkg::PC_SEQ && pred_taken_i) begin
            sel = bp_pkg::PC_PRED;
        end else begin
            sel = pc_sel_i;
        end
    end

    always_comb begin
        case (sel)
            bp_pkg::PC_PRED:       pc_next = pred_target_i;
            bp_pkg::PC_REDIR_FALL: pc_next = redirect_pc_i + `BP_INSTR_BYTES;
            bp_pkg::PC_REDIR_TGT:  pc_next = redirect_pc_i;
            default:               pc_next = pc_q + `BP_INSTR_BYTES;
        endcase
    end

    // Stall holds the PC but a redirect still wins
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc_q <= `BP_RESET_PC;
        end else if (!stall_i || pc_sel_i != bp_pkg::PC_SEQ) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // Targets from the BTB and from execute must both be word aligned
    pc_aligned_a: assert property (
        @(posedge clk_i) disable iff (rst_i) pc_q[1:0] == 2'b00
    ) else $error("fetch PC %h is not word aligned", pc_q);

endmodule

// File: rtl/fetch_predictor_top.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module fetch_predictor_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  bp_pkg::resolve_t    resolve_i,
    output bp_pkg::fetch_pred_t fetch_o,
    output logic                flush_o
);

    logic [31:0]           pc;
    logic                  btb_hit;
    logic [31:0]           btb_target;
    logic                  guess;
    logic                  pred_taken;
    bp_pkg::table_update_t update;
    bp_pkg::pc_sel_e       pc_sel;
    logic [31:0]           redirect_pc;

    // Taken only when the BTB knows a target
    assign pred_taken = btb_hit && guess;

    fetch_pc u_fetch_pc (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .pred_taken_i  (pred_taken),
        .pred_target_i (btb_target),
        .pc_sel_i      (pc_sel),
        .redirect_pc_i (redirect_pc),
        .pc_o          (pc)
    );

    btb u_btb (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .lookup_pc_i (pc),
        .update_i    (update),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    // Counters are indexed without a tag check
    pattern_table u_pattern_table (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_index_i (pc[`BP_INDEX_WIDTH+1:2]),
        .update_i       (update),
        .guess_o        (guess)
    );

    mispredict_unit u_mispredict_unit (
        .resolve_i     (resolve_i),
        .update_o      (update),
        .pc_sel_o      (pc_sel),
        .redirect_pc_o (redirect_pc),
        .flush_o       (flush_o)
    );

    assign fetch_o.pc          = pc;
    assign fetch_o.pred_taken  = pred_taken;
    assign fetch_o.pred_target = btb_target;

endmodule

// File: verif/tb_fetch_predictor.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module tb_fetch_predictor;

    localparam int DEPTH = 1 << `BP_INDEX_WIDTH;
    // Tests take under 200 cycles including reset
    localparam int MAX_CYCLES = 400;
    // Index reserved for the jumps that steer fetch between tests
    localparam int JUMP_IDX = DEPTH - 1;
    localparam bp_pkg::resolve_t NO_RESOLVE = '0;

    logic                clk_i;
    logic                rst_i;
    logic                stall_i;
    bp_pkg::resolve_t    resolve_i;
    bp_pkg::fetch_pred_t fetch_o;
    logic                flush_o;

    int seed = 32'h40ea2fef;
    int errors = 0;
    int cycle_count = 0;

    // Reference model of the predictor state
    bp_pkg::counter_e  m_cnt    [DEPTH];
    logic              m_valid  [DEPTH];
    bp_pkg::bp_tag_t   m_tag    [DEPTH];
    logic [31:0]       m_target [DEPTH];
    logic [31:0]       m_pc;

    // Branch and target shared by the taken and not-taken tests
    logic [31:0] br_pc;
    logic [31:0] br_target;
    logic [31:0] c_pc;
    logic [31:0] c_target;

    fetch_predictor_top uut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .resolve_i (resolve_i),
        .fetch_o   (fetch_o),
        .flush_o   (flush_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without reaching the end of the tests",
                     cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_fetch(input string name, input bp_pkg::fetch_pred_t actual,
                               input bp_pkg::fetch_pred_t expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail time=%0t signal=%s actual=%b expected=%b",
                     $time, name, actual, expected);
        end
    endtask

    function automatic bp_pkg::bp_index_t idx_of(input logic [31:0] pc);
        return pc[`BP_INDEX_WIDTH+1:2];
    endfunction

    function automatic bp_pkg::bp_tag_t tag_of(input logic [31:0] pc);
        return pc[31:`BP_INDEX_WIDTH+2];
    endfunction

    // Random word-aligned PC that lands on a chosen table index
    function automatic logic [31:0] pc_at(input int idx);
        logic [31:0] r;
        r = $random(seed);
        r[`BP_INDEX_WIDTH+1:2] = idx[`BP_INDEX_WIDTH-1:0];
        r[1:0] = 2'b00;
        return r;
    endfunction

    // One saturating step toward the outcome
    function automatic bp_pkg::counter_e train(input bp_pkg::counter_e cur,
                                               input logic taken);
        logic [1:0] v;
        v = cur;
        if (taken && v != 2'b11) begin
            v = v + 2'b01;
        end else if (!taken && v != 2'b00) begin
            v = v - 2'b01;
        end
        return bp_pkg::counter_e'(v);
    endfunction

    function automatic bp_pkg::fetch_pred_t model_fetch(input logic [31:0] pc);
        bp_pkg::fetch_pred_t f;
        bp_pkg::bp_index_t   idx;
        logic                hit;
        idx = idx_of(pc);
        hit = m_valid[idx] && (m_tag[idx] == tag_of(pc));
        f.pc          = pc;
        f.pred_taken  = hit && m_cnt[idx][1];
        f.pred_target = hit ? m_target[idx] : 32'h0000_0000;
        return f;
    endfunction

    function automatic logic is_mispredict(input bp_pkg::resolve_t res);
        logic wrong_target;
        wrong_target = res.taken && res.pred_taken && (res.target != res.pred_target);
        return res.valid && ((res.taken != res.pred_taken) || wrong_target);
    endfunction

    // Resolve carrying the prediction that fetch gives for this PC now
    function automatic bp_pkg::resolve_t resolve_for(input logic [31:0] pc, input logic taken,
                                                     input logic [31:0] target);
        bp_pkg::resolve_t    res;
        bp_pkg::fetch_pred_t pred;
        pred = model_fetch(pc);
        res.valid       = 1'b1;
        res.taken       = taken;
        res.pc          = pc;
        res.target      = target;
        res.pred_taken  = pred.pred_taken;
        res.pred_target = pred.pred_target;
        return res;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < DEPTH; i++) begin
            m_cnt[i]    = bp_pkg::CNT_WEAK_NT;
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = 32'h0000_0000;
        end
        m_pc = `BP_RESET_PC;
    endtask

    // Called 10 ns after a rising edge, returns 10 ns after the next one
    task automatic run_cycle(input logic stall, input bp_pkg::resolve_t res);
        bp_pkg::fetch_pred_t exp;
        logic                exp_flush;
        bp_pkg::bp_index_t   ridx;
        stall_i   = stall;
        resolve_i = res;
        exp       = model_fetch(m_pc);
        exp_flush = is_mispredict(res);
        #40;
        check_fetch("fetch_o", fetch_o, exp);
        check_bit("flush_o", flush_o, exp_flush);
        if (exp_flush) begin
            m_pc = res.taken ? res.target : res.pc + `BP_INSTR_BYTES;
        end else if (!stall) begin
            m_pc = exp.pred_taken ? exp.pred_target : m_pc + `BP_INSTR_BYTES;
        end
        if (res.valid) begin
            ridx = idx_of(res.pc);
            m_cnt[ridx] = train(m_cnt[ridx], res.taken);
            if (res.taken) begin
                m_valid[ridx]  = 1'b1;
                m_tag[ridx]    = tag_of(res.pc);
                m_target[ridx] = res.target;
            end
        end
        @(posedge clk_i);
        #10;
    endtask

    task automatic idle(input int n);
        repeat (n) run_cycle(1'b0, NO_RESOLVE);
    endtask

    // Unpredicted jump from a spare PC so fetch lands on dest
    task automatic jump_to(input logic [31:0] dest);
        run_cycle(1'b0, resolve_for(pc_at(JUMP_IDX), 1'b1, dest));
    endtask

    // Outputs here come only from registers, settled since the edge
    task automatic expect_fetch(input logic [31:0] pc, input logic taken,
                                input logic [31:0] target);
        bp_pkg::fetch_pred_t exp;
        exp.pc          = pc;
        exp.pred_taken  = taken;
        exp.pred_target = target;
        check_fetch("fetch_o", fetch_o, exp);
    endtask

    task automatic test_sequential_and_stall();
        expect_fetch(`BP_RESET_PC, 1'b0, 32'h0);
        idle(5);
        expect_fetch(`BP_RESET_PC + 5 * `BP_INSTR_BYTES, 1'b0, 32'h0);
        repeat (3) run_cycle(1'b1, NO_RESOLVE);
        expect_fetch(`BP_RESET_PC + 5 * `BP_INSTR_BYTES, 1'b0, 32'h0);
        idle(2);
        expect_fetch(`BP_RESET_PC + 7 * `BP_INSTR_BYTES, 1'b0, 32'h0);
    endtask

    task automatic test_taken_not_predicted();
        br_pc     = pc_at(10);
        br_target = pc_at(20);
        jump_to(br_pc);
        expect_fetch(br_pc, 1'b0, 32'h0);
        run_cycle(1'b0, resolve_for(br_pc, 1'b1, br_target));
        expect_fetch(br_target, 1'b0, 32'h0);
        // Counter is now weak taken and the BTB holds the target
        jump_to(br_pc);
        expect_fetch(br_pc, 1'b1, br_target);
    endtask

    task automatic test_predicted_not_taken();
        run_cycle(1'b0, resolve_for(br_pc, 1'b0, br_target));
        expect_fetch(br_pc + `BP_INSTR_BYTES, 1'b0, 32'h0);
        jump_to(br_pc);
        expect_fetch(br_pc, 1'b0, br_target);
    endtask

    task automatic test_saturation();
        c_pc     = pc_at(30);
        c_target = pc_at(40);
        repeat (3) run_cycle(1'b0, resolve_for(c_pc, 1'b1, c_target));
        run_cycle(1'b0, resolve_for(c_pc, 1'b0, c_target));
        jump_to(c_pc);
        expect_fetch(c_pc, 1'b1, c_target);
    endtask

    task automatic test_correct_and_wrong_target();
        logic [31:0] new_target;
        run_cycle(1'b0, resolve_for(c_pc, 1'b1, c_target));
        expect_fetch(c_target, 1'b0, 32'h0);
        // Wrong target under stall still redirects
        new_target = pc_at(50);
        run_cycle(1'b1, resolve_for(c_pc, 1'b1, new_target));
        expect_fetch(new_target, 1'b0, 32'h0);
        jump_to(c_pc);
        expect_fetch(c_pc, 1'b1, new_target);
    endtask

    task automatic test_tag_alias();
        logic [31:0] alias_pc;
        alias_pc = c_pc ^ (32'h1 << (`BP_INDEX_WIDTH + 2));
        jump_to(alias_pc);
        expect_fetch(alias_pc, 1'b0, 32'h0);
        idle(1);
        expect_fetch(alias_pc + `BP_INSTR_BYTES, 1'b0, 32'h0);
    endtask

    initial begin
        rst_i     = 1'b1;
        stall_i   = 1'b0;
        resolve_i = NO_RESOLVE;
        model_reset();
        repeat (8) @(posedge clk_i);
        #10;
        rst_i = 1'b0;

        test_sequential_and_stall();
        test_taken_not_predicted();
        test_predicted_not_taken();
        test_saturation();
        test_correct_and_wrong_target();
        test_tag_alias();
        idle(2);

        $display("Errors: %0d after %0d cycles", errors, cycle_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: fetch_predictor_top.f
+incdir+rtl
rtl/bp_pkg.sv
rtl/btb.sv
rtl/pattern_table.sv
rtl/mispredict_unit.sv
rtl/fetch_pc.sv
rtl/fetch_predictor_top.sv
verif/tb_fetch_predictor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch predictor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_fetch_predictor \
    -f fetch_predictor_top.f \
    -Mdir obj_dir \
    -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -q "TEST PASSED" "$LOG"; then
    echo "Simulation passed, log in $LOG"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
